/* verilog/remote_port_pkg.sv */
`default_nettype none

package remote_port_pkg;

  localparam int data_width = 32;
  localparam int addr_width = 28;
  localparam int x_cord_width = 4;
  localparam int y_cord_width = 4;
  localparam int reg_id_width = 5;
  localparam int op_ex_width = 4;

  // tile array and the vcache row below it
  localparam int num_tiles_x = 4;
  localparam int dram_y_cord = 8;
  localparam int dram_block_offset_width = 3;
  localparam int dram_col_width = $clog2(num_tiles_x);

  localparam int max_out_credits = 8;
  localparam int credit_width = 4;

  localparam int req_fifo_depth = 4;
  localparam int ret_fifo_depth = 4;

  typedef enum logic [1:0] {
    e_remote_load,
    e_remote_store,
    e_remote_amo
  } packet_op_e;

  typedef enum logic [1:0] {
    e_return_ifetch,
    e_return_int_wb,
    e_return_float_wb,
    e_return_credit
  } return_type_e;

  typedef struct packed {
    logic [data_width-1:0]   addr;
    logic [data_width-1:0]   data;
    logic [op_ex_width-1:0]  mask;
    logic [op_ex_width-1:0]  amo_type;
    logic [reg_id_width-1:0] reg_id;
    logic                    write_not_read;
    logic                    is_amo;
    logic                    is_float;
  } remote_req_s;

  typedef struct packed {
    return_type_e            pkt_type;
    logic [reg_id_width-1:0] reg_id;
    logic [data_width-1:0]   data;
  } return_entry_s;

  // msb first, 87 bits
  typedef struct packed {
    packet_op_e              op;
    logic [op_ex_width-1:0]  op_ex;
    logic [reg_id_width-1:0] reg_id;
    logic [data_width-1:0]   payload;
    logic [addr_width-1:0]   addr;
    logic [y_cord_width-1:0] y_cord;
    logic [x_cord_width-1:0] x_cord;
    logic [y_cord_width-1:0] src_y_cord;
    logic [x_cord_width-1:0] src_x_cord;
  } network_packet_s;

  localparam int packet_width = $bits(network_packet_s);

endpackage

`default_nettype wire

/* verilog/eva_to_npa.sv */
`timescale 1ns/1ns
`default_nettype none

module eva_to_npa (
  input  logic [remote_port_pkg::data_width-1:0]   eva_i,
  input  logic                                     dram_enable_i,
  input  logic [remote_port_pkg::x_cord_width-1:0] tgo_x_i,
  input  logic [remote_port_pkg::y_cord_width-1:0] tgo_y_i,
  output logic [remote_port_pkg::x_cord_width-1:0] x_cord_o,
  output logic [remote_port_pkg::y_cord_width-1:0] y_cord_o,
  output logic [remote_port_pkg::addr_width-1:0]   epa_o,
  output logic                                     is_invalid_addr_o
);

  // word address inside the dram region, region bit dropped
  logic [remote_port_pkg::data_width-4:0] dram_word;

  assign dram_word = eva_i[remote_port_pkg::data_width-2:2];

  always_comb begin
    if (eva_i[31]) begin
      // dram, blocks striped across columns
      x_cord_o = remote_port_pkg::x_cord_width'(
        dram_word[remote_port_pkg::dram_block_offset_width +: remote_port_pkg::dram_col_width]);
      y_cord_o = remote_port_pkg::y_cord_width'(remote_port_pkg::dram_y_cord);
      epa_o = remote_port_pkg::addr_width'({
        dram_word[remote_port_pkg::data_width-4:
          remote_port_pkg::dram_block_offset_width + remote_port_pkg::dram_col_width],
        dram_word[remote_port_pkg::dram_block_offset_width-1:0]});
      is_invalid_addr_o = ~dram_enable_i;
    end else if (eva_i[30]) begin
      // global tile
      x_cord_o = eva_i[27:24];
      y_cord_o = eva_i[23:20];
      epa_o = remote_port_pkg::addr_width'(eva_i[19:2]);
      is_invalid_addr_o = |eva_i[1:0];
    end else begin
      // group tile, offset from tile group origin
      x_cord_o = tgo_x_i + eva_i[27:24];
      y_cord_o = tgo_y_i + eva_i[23:20];
      epa_o = remote_port_pkg::addr_width'(eva_i[19:2]);
      is_invalid_addr_o = |eva_i[1:0];
    end
  end

endmodule

`default_nettype wire

/* verilog/remote_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module remote_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  depth   = 4
) (
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   v_i,
  input  entry_t data_i,
  output logic   full_o,
  output logic   v_o,
  output entry_t data_o,
  input  logic   yumi_i
);

  entry_t mem [depth];

  logic [$clog2(depth)-1:0]   wptr_r;
  logic [$clog2(depth)-1:0]   rptr_r;
  logic [$clog2(depth+1)-1:0] count_r;

  assign full_o = (count_r == depth);
  assign v_o = (count_r != '0);
  assign data_o = mem[rptr_r];

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      mem[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      count_r <= '0;
    end else begin
      if (v_i) begin
        wptr_r <= (wptr_r == depth - 1) ? '0 : wptr_r + 1'b1;
      end
      if (yumi_i) begin
        rptr_r <= (rptr_r == depth - 1) ? '0 : rptr_r + 1'b1;
      end
      case ({v_i, yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // producer must watch full, consumer must watch valid
  assert property (@(posedge clk_i) disable iff (reset_i) !(v_i && full_o))
    else $error("remote_fifo: push while full");
  assert property (@(posedge clk_i) disable iff (reset_i) !(yumi_i && !v_o))
    else $error("remote_fifo: pop while empty");

endmodule

`default_nettype wire

/* verilog/credit_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module credit_counter (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  logic                                     take_i,
  input  logic                                     return_i,
  output logic [remote_port_pkg::credit_width-1:0] count_o,
  output logic                                     avail_o
);

  logic [remote_port_pkg::credit_width-1:0] count_r;

  assign count_o = count_r;
  assign avail_o = (count_r != '0);

  // take and return together leave the count alone
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= remote_port_pkg::credit_width'(remote_port_pkg::max_out_credits);
    end else if (take_i && !return_i) begin
      count_r <= count_r - 1'b1;
    end else if (return_i && !take_i) begin
      count_r <= count_r + 1'b1;
    end
  end

  // network returns no more credits than were sent
  assert property (@(posedge clk_i) disable iff (reset_i)
    count_r <= remote_port_pkg::max_out_credits)
    else $error("credit_counter: count above limit");
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(take_i && !return_i && count_r == '0))
    else $error("credit_counter: take with no credit");

endmodule

`default_nettype wire

/* verilog/fence_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module fence_fsm (
  input  logic clk_i,
  input  logic reset_i,
  input  logic fence_i,
  input  logic credits_full_i,
  output logic send_en_o,
  output logic fence_done_o
);

  typedef enum logic {
    s_idle,
    s_drain
  } fence_state_e;

  fence_state_e state_r;
  fence_state_e state_n;

  // nothing leaves in the fence cycle itself
  assign send_en_o = (state_r == s_idle) && !fence_i;
  assign fence_done_o = (state_r == s_drain) && credits_full_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle: begin
        if (fence_i) begin
          state_n = s_drain;
        end
      end
      s_drain: begin
        if (credits_full_i) begin
          state_n = s_idle;
        end
      end
      default: state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

`default_nettype wire

/* verilog/network_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module network_tx (
  // request queue head
  input  logic                                     req_v_i,
  input  remote_port_pkg::remote_req_s             req_i,
  output logic                                     req_yumi_o,
  input  logic                                     credit_avail_i,
  input  logic                                     send_en_i,
  output logic                                     credit_take_o,
  output logic [remote_port_pkg::packet_width-1:0] out_packet_o,
  output logic                                     out_v_o,
  output logic                                     invalid_eva_access_o,
  output logic                                     req_credit_o,
  input  logic [remote_port_pkg::x_cord_width-1:0] tgo_x_i,
  input  logic [remote_port_pkg::y_cord_width-1:0] tgo_y_i,
  input  logic [remote_port_pkg::x_cord_width-1:0] my_x_i,
  input  logic [remote_port_pkg::y_cord_width-1:0] my_y_i,
  input  logic                                     dram_enable_i,
  // return queue head
  input  logic                                     ret_v_i,
  input  remote_port_pkg::return_entry_s           ret_i,
  input  logic                                     ret_full_i,
  output logic                                     ret_yumi_o,
  output logic                                     ifetch_v_o,
  output logic [remote_port_pkg::data_width-1:0]   ifetch_instr_o,
  output logic                                     int_resp_v_o,
  output logic [remote_port_pkg::reg_id_width-1:0] int_resp_rd_o,
  output logic [remote_port_pkg::data_width-1:0]   int_resp_data_o,
  output logic                                     int_resp_force_o,
  input  logic                                     int_resp_yumi_i,
  output logic                                     float_resp_v_o,
  output logic [remote_port_pkg::reg_id_width-1:0] float_resp_rd_o,
  output logic [remote_port_pkg::data_width-1:0]   float_resp_data_o,
  output logic                                     float_resp_force_o,
  input  logic                                     float_resp_yumi_i
);

  remote_port_pkg::network_packet_s out_packet;

  logic                                     is_invalid_addr;
  logic [remote_port_pkg::x_cord_width-1:0] x_cord;
  logic [remote_port_pkg::y_cord_width-1:0] y_cord;
  logic [remote_port_pkg::addr_width-1:0]   epa;
  logic                                     force_pop;

  eva_to_npa eva2npa (
    .eva_i            (req_i.addr),
    .dram_enable_i    (dram_enable_i),
    .tgo_x_i          (tgo_x_i),
    .tgo_y_i          (tgo_y_i),
    .x_cord_o         (x_cord),
    .y_cord_o         (y_cord),
    .epa_o            (epa),
    .is_invalid_addr_o(is_invalid_addr)
  );

  always_comb begin
    if (req_i.is_amo) begin
      out_packet.op = remote_port_pkg::e_remote_amo;
    end else if (req_i.write_not_read) begin
      out_packet.op = remote_port_pkg::e_remote_store;
    end else begin
      out_packet.op = remote_port_pkg::e_remote_load;
    end
    out_packet.op_ex = req_i.is_amo ? req_i.amo_type : req_i.mask;
    out_packet.reg_id = req_i.reg_id;
    // loads carry only the float flag back as load info
    if (req_i.write_not_read || req_i.is_amo) begin
      out_packet.payload = req_i.data;
    end else begin
      out_packet.payload = {{(remote_port_pkg::data_width-1){1'b0}}, req_i.is_float};
    end
    out_packet.addr = epa;
    out_packet.y_cord = y_cord;
    out_packet.x_cord = x_cord;
    out_packet.src_y_cord = my_y_i;
    out_packet.src_x_cord = my_x_i;
  end

  assign out_packet_o = out_packet;

  // send, drop or wait
  assign invalid_eva_access_o = req_v_i && is_invalid_addr;
  assign out_v_o = req_v_i && !is_invalid_addr && credit_avail_i && send_en_i;
  assign credit_take_o = out_v_o;
  assign req_yumi_o = out_v_o || invalid_eva_access_o;
  assign req_credit_o = req_yumi_o;

  assign ifetch_instr_o = ret_i.data;
  assign int_resp_rd_o = ret_i.reg_id;
  assign int_resp_data_o = ret_i.data;
  assign float_resp_rd_o = ret_i.reg_id;
  assign float_resp_data_o = ret_i.data;

  // a full return queue cannot wait on the core
  assign force_pop = ret_v_i && ret_full_i;

  always_comb begin
    ifetch_v_o = 1'b0;
    int_resp_v_o = 1'b0;
    int_resp_force_o = 1'b0;
    float_resp_v_o = 1'b0;
    float_resp_force_o = 1'b0;
    case (ret_i.pkt_type)
      remote_port_pkg::e_return_ifetch: begin
        ifetch_v_o = ret_v_i;
        ret_yumi_o = ret_v_i;
      end
      remote_port_pkg::e_return_float_wb: begin
        float_resp_v_o = ret_v_i;
        float_resp_force_o = force_pop;
        ret_yumi_o = (ret_v_i && float_resp_yumi_i) || force_pop;
      end
      remote_port_pkg::e_return_int_wb: begin
        int_resp_v_o = ret_v_i;
        int_resp_force_o = force_pop;
        ret_yumi_o = (ret_v_i && int_resp_yumi_i) || force_pop;
      end
      // credits never reach the core; discard
      default: ret_yumi_o = ret_v_i;
    endcase
  end

  always_comb begin
    assert final (!(ret_v_i && ret_i.pkt_type == remote_port_pkg::e_return_credit))
      else $error("network_tx: credit packet in return queue");
  end

endmodule

`default_nettype wire

/* verilog/remote_port.sv */
`timescale 1ns/1ns
`default_nettype none

module remote_port (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  // core requests
  input  logic                                     remote_req_v_i,
  input  logic [remote_port_pkg::data_width-1:0]   remote_req_addr_i,
  input  logic [remote_port_pkg::data_width-1:0]   remote_req_data_i,
  input  logic [remote_port_pkg::op_ex_width-1:0]  remote_req_mask_i,
  input  logic [remote_port_pkg::op_ex_width-1:0]  remote_req_amo_type_i,
  input  logic [remote_port_pkg::reg_id_width-1:0] remote_req_reg_id_i,
  input  logic                                     remote_req_write_not_read_i,
  input  logic                                     remote_req_is_amo_i,
  input  logic                                     remote_req_is_float_i,
  output logic                                     remote_req_credit_o,
  input  logic                                     fence_i,
  output logic                                     fence_done_o,
  // network
  output logic [remote_port_pkg::packet_width-1:0] out_packet_o,
  output logic                                     out_v_o,
  input  logic                                     out_credit_i,
  input  logic                                     returned_v_i,
  input  remote_port_pkg::return_type_e            returned_type_i,
  input  logic [remote_port_pkg::reg_id_width-1:0] returned_reg_id_i,
  input  logic [remote_port_pkg::data_width-1:0]   returned_data_i,
  // location
  input  logic [remote_port_pkg::x_cord_width-1:0] tgo_x_i,
  input  logic [remote_port_pkg::y_cord_width-1:0] tgo_y_i,
  input  logic [remote_port_pkg::x_cord_width-1:0] my_x_i,
  input  logic [remote_port_pkg::y_cord_width-1:0] my_y_i,
  input  logic                                     dram_enable_i,
  // responses to core
  output logic                                     ifetch_v_o,
  output logic [remote_port_pkg::data_width-1:0]   ifetch_instr_o,
  output logic                                     int_resp_v_o,
  output logic [remote_port_pkg::reg_id_width-1:0] int_resp_rd_o,
  output logic [remote_port_pkg::data_width-1:0]   int_resp_data_o,
  output logic                                     int_resp_force_o,
  input  logic                                     int_resp_yumi_i,
  output logic                                     float_resp_v_o,
  output logic [remote_port_pkg::reg_id_width-1:0] float_resp_rd_o,
  output logic [remote_port_pkg::data_width-1:0]   float_resp_data_o,
  output logic                                     float_resp_force_o,
  input  logic                                     float_resp_yumi_i,
  output logic                                     invalid_eva_access_o
);

  remote_port_pkg::remote_req_s   req_in;
  remote_port_pkg::remote_req_s   req_head;
  remote_port_pkg::return_entry_s ret_in;
  remote_port_pkg::return_entry_s ret_head;

  logic req_head_v, req_yumi;
  logic ret_head_v, ret_yumi, ret_full;
  logic credit_take, credit_avail, credits_full, send_en;
  logic [remote_port_pkg::credit_width-1:0] credit_count;

  assign req_in.addr = remote_req_addr_i;
  assign req_in.data = remote_req_data_i;
  assign req_in.mask = remote_req_mask_i;
  assign req_in.amo_type = remote_req_amo_type_i;
  assign req_in.reg_id = remote_req_reg_id_i;
  assign req_in.write_not_read = remote_req_write_not_read_i;
  assign req_in.is_amo = remote_req_is_amo_i;
  assign req_in.is_float = remote_req_is_float_i;

  assign ret_in.pkt_type = returned_type_i;
  assign ret_in.reg_id = returned_reg_id_i;
  assign ret_in.data = returned_data_i;

  assign credits_full =
    (credit_count == remote_port_pkg::credit_width'(remote_port_pkg::max_out_credits));

  // core credit scheme keeps this queue from overflowing
  remote_fifo #(
    .entry_t(remote_port_pkg::remote_req_s),
    .depth  (remote_port_pkg::req_fifo_depth)
  ) req_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (remote_req_v_i),
    .data_i (req_in),
    .full_o (),
    .v_o    (req_head_v),
    .data_o (req_head),
    .yumi_i (req_yumi)
  );

  remote_fifo #(
    .entry_t(remote_port_pkg::return_entry_s),
    .depth  (remote_port_pkg::ret_fifo_depth)
  ) ret_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (returned_v_i),
    .data_i (ret_in),
    .full_o (ret_full),
    .v_o    (ret_head_v),
    .data_o (ret_head),
    .yumi_i (ret_yumi)
  );

  credit_counter credits (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .take_i  (credit_take),
    .return_i(out_credit_i),
    .count_o (credit_count),
    .avail_o (credit_avail)
  );

  fence_fsm fence (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fence_i       (fence_i),
    .credits_full_i(credits_full),
    .send_en_o     (send_en),
    .fence_done_o  (fence_done_o)
  );

  network_tx tx (
    .req_v_i             (req_head_v),
    .req_i               (req_head),
    .req_yumi_o          (req_yumi),
    .credit_avail_i      (credit_avail),
    .send_en_i           (send_en),
    .credit_take_o       (credit_take),
    .out_packet_o        (out_packet_o),
    .out_v_o             (out_v_o),
    .invalid_eva_access_o(invalid_eva_access_o),
    .req_credit_o        (remote_req_credit_o),
    .tgo_x_i             (tgo_x_i),
    .tgo_y_i             (tgo_y_i),
    .my_x_i              (my_x_i),
    .my_y_i              (my_y_i),
    .dram_enable_i       (dram_enable_i),
    .ret_v_i             (ret_head_v),
    .ret_i               (ret_head),
    .ret_full_i          (ret_full),
    .ret_yumi_o          (ret_yumi),
    .ifetch_v_o          (ifetch_v_o),
    .ifetch_instr_o      (ifetch_instr_o),
    .int_resp_v_o        (int_resp_v_o),
    .int_resp_rd_o       (int_resp_rd_o),
    .int_resp_data_o     (int_resp_data_o),
    .int_resp_force_o    (int_resp_force_o),
    .int_resp_yumi_i     (int_resp_yumi_i),
    .float_resp_v_o      (float_resp_v_o),
    .float_resp_rd_o     (float_resp_rd_o),
    .float_resp_data_o   (float_resp_data_o),
    .float_resp_force_o  (float_resp_force_o),
    .float_resp_yumi_i   (float_resp_yumi_i)
  );

endmodule

`default_nettype wire

/* verif/remote_port_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module remote_port_tb;

  logic        clk_i;
  logic        reset_i;
  logic        remote_req_v_i;
  logic [31:0] remote_req_addr_i;
  logic [31:0] remote_req_data_i;
  logic [3:0]  remote_req_mask_i;
  logic [3:0]  remote_req_amo_type_i;
  logic [4:0]  remote_req_reg_id_i;
  logic        remote_req_write_not_read_i;
  logic        remote_req_is_amo_i;
  logic        remote_req_is_float_i;
  logic        remote_req_credit_o;
  logic        fence_i;
  logic        fence_done_o;
  logic [remote_port_pkg::packet_width-1:0] out_packet_o;
  logic        out_v_o;
  logic        out_credit_i;
  logic        returned_v_i;
  remote_port_pkg::return_type_e returned_type_i;
  logic [4:0]  returned_reg_id_i;
  logic [31:0] returned_data_i;
  logic [3:0]  tgo_x_i;
  logic [3:0]  tgo_y_i;
  logic [3:0]  my_x_i;
  logic [3:0]  my_y_i;
  logic        dram_enable_i;
  logic        ifetch_v_o;
  logic [31:0] ifetch_instr_o;
  logic        int_resp_v_o;
  logic [4:0]  int_resp_rd_o;
  logic [31:0] int_resp_data_o;
  logic        int_resp_force_o;
  logic        int_resp_yumi_i;
  logic        float_resp_v_o;
  logic [4:0]  float_resp_rd_o;
  logic [31:0] float_resp_data_o;
  logic        float_resp_force_o;
  logic        float_resp_yumi_i;
  logic        invalid_eva_access_o;

  integer seed;
  int issued_count, credit_back_count, sent_count, returned_count;
  int ret_todo, ret_occ, dut_out;
  bit hold_credits, in_fence, ret_pop;
  bit ret_head_v;
  remote_port_pkg::return_type_e ret_head_type;
  remote_port_pkg::network_packet_s exp_pkt_q[$];
  bit exp_inv_q[$];
  remote_port_pkg::return_entry_s exp_ret_q[$];
  remote_port_pkg::return_entry_s ret_entry;

  remote_port dut (.*);

  always #2 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [95:0] got, input logic [95:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // reference translation and packet build
  function automatic remote_port_pkg::network_packet_s model_packet(
    input logic [31:0] addr, input logic [31:0] data, input logic [3:0] mask,
    input logic [3:0] amo_type, input logic [4:0] reg_id, input logic wnr,
    input logic amo, input logic fp);
    remote_port_pkg::network_packet_s p;
    int unsigned word;
    word = addr[30:2];
    if (addr[31]) begin
      // 8-word blocks dealt round the columns
      p.x_cord = 4'((word / 8) % remote_port_pkg::num_tiles_x);
      p.y_cord = 4'(remote_port_pkg::dram_y_cord);
      p.addr = 28'((word / (8 * remote_port_pkg::num_tiles_x)) * 8 + word % 8);
    end else begin
      p.x_cord = addr[27:24] + (addr[30] ? 4'd0 : tgo_x_i);
      p.y_cord = addr[23:20] + (addr[30] ? 4'd0 : tgo_y_i);
      p.addr = 28'(addr[19:2]);
    end
    if (amo) begin
      p.op = remote_port_pkg::e_remote_amo;
    end else if (wnr) begin
      p.op = remote_port_pkg::e_remote_store;
    end else begin
      p.op = remote_port_pkg::e_remote_load;
    end
    p.op_ex = amo ? amo_type : mask;
    p.reg_id = reg_id;
    p.payload = (amo || wnr) ? data : {31'b0, fp};
    p.src_y_cord = my_y_i;
    p.src_x_cord = my_x_i;
    return p;
  endfunction

  function automatic bit model_invalid(input logic [31:0] addr);
    if (addr[31]) begin
      return !dram_enable_i;
    end
    return addr[1:0] != 2'b00;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    remote_req_v_i = 1'b0;
    fence_i = 1'b0;
  endtask

  // kind 0 group, 1 global, 2 dram, 3 misaligned tile access
  task automatic issue_request(input int kind);
    logic [31:0] addr;
    int waited;
    waited = 0;
    next_cycle();
    while (issued_count - credit_back_count >= remote_port_pkg::req_fifo_depth) begin
      waited++;
      if (waited > 200) begin
        report_failure("core request credit never came back");
      end
      next_cycle();
    end
    addr = $random(seed);
    case (kind)
      0: addr[31:30] = 2'b00;
      1: addr[31:30] = 2'b01;
      2: addr[31] = 1'b1;
      default: addr[31] = 1'b0;
    endcase
    if (kind != 3) begin
      addr[1:0] = 2'b00;
    end else if (addr[1:0] == 2'b00) begin
      addr[1:0] = 2'b10;
    end
    remote_req_addr_i = addr;
    remote_req_data_i = $random(seed);
    remote_req_mask_i = $random(seed);
    remote_req_amo_type_i = $random(seed);
    remote_req_reg_id_i = $random(seed);
    remote_req_write_not_read_i = $random(seed);
    remote_req_is_amo_i = (($random(seed) & 3) == 0);
    remote_req_is_float_i = $random(seed);
    remote_req_v_i = 1'b1;
    issued_count++;
    exp_inv_q.push_back(model_invalid(addr));
    exp_pkt_q.push_back(model_packet(addr, remote_req_data_i, remote_req_mask_i,
      remote_req_amo_type_i, remote_req_reg_id_i, remote_req_write_not_read_i,
      remote_req_is_amo_i, remote_req_is_float_i));
  endtask

  // queue empty and every credit back home
  task automatic wait_requests_done();
    int waited;
    waited = 0;
    while (exp_inv_q.size() != 0 || sent_count != returned_count) begin
      waited++;
      if (waited > 1000) begin
        report_failure("requests did not drain from the port");
      end
      next_cycle();
    end
    // one core credit for every request that left the queue
    compare("remote_req_credit_o pulses", credit_back_count, issued_count);
  endtask

  task automatic wait_fence_done(input int limit);
    int waited;
    waited = 0;
    while (in_fence) begin
      waited++;
      if (waited > limit) begin
        report_failure("fence did not complete in time");
      end
      next_cycle();
    end
  endtask

  task automatic wait_returns_done();
    int waited;
    waited = 0;
    while (ret_todo != 0 || exp_ret_q.size() != 0) begin
      waited++;
      if (waited > 2000) begin
        report_failure("returned packets never reached the core");
      end
      next_cycle();
    end
  endtask

  task automatic check_return(input remote_port_pkg::return_type_e kind, input string stream,
    input logic [4:0] rd, input logic [31:0] data);
    remote_port_pkg::return_entry_s e;
    if (exp_ret_q.size() == 0) begin
      report_failure({stream, " response with no returned packet pending"});
    end
    e = exp_ret_q.pop_front();
    compare({stream, " return type"}, e.pkt_type, kind);
    if (kind != remote_port_pkg::e_return_ifetch) begin
      compare({stream, "_rd_o"}, rd, e.reg_id);
    end
    compare({stream, " data"}, data, e.data);
    ret_pop = 1'b1;
  endtask

  // network and core models, driven just after the edge
  always @(posedge clk_i) begin
    #1;
    returned_v_i = 1'b0;
    out_credit_i = 1'b0;
    int_resp_yumi_i = 1'b0;
    float_resp_yumi_i = 1'b0;
    if (!reset_i) begin
      int_resp_yumi_i = int_resp_v_o && (($random(seed) & 3) == 0);
      float_resp_yumi_i = float_resp_v_o && (($random(seed) & 3) == 0);
      if (ret_todo > 0 && ret_occ < remote_port_pkg::ret_fifo_depth && ($random(seed) & 1)) begin
        ret_entry.pkt_type = remote_port_pkg::return_type_e'($unsigned($random(seed)) % 3);
        ret_entry.reg_id = $random(seed);
        ret_entry.data = $random(seed);
        returned_type_i = ret_entry.pkt_type;
        returned_reg_id_i = ret_entry.reg_id;
        returned_data_i = ret_entry.data;
        returned_v_i = 1'b1;
        exp_ret_q.push_back(ret_entry);
        ret_todo--;
      end
      if (!hold_credits && sent_count > returned_count && (($random(seed) & 3) == 0)) begin
        out_credit_i = 1'b1;
        returned_count++;
      end
    end
  end

  // monitor at the falling edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (remote_req_credit_o) begin
        credit_back_count++;
      end
      dut_out = sent_count - (returned_count - out_credit_i);
      if (out_v_o) begin
        if (in_fence) begin
          report_failure("packet sent while a fence was draining");
        end
        if (dut_out >= remote_port_pkg::max_out_credits) begin
          report_failure("packet sent with no network credit left");
        end
        if (exp_inv_q.size() == 0) begin
          report_failure("packet sent with no request pending");
        end
        if (exp_inv_q.pop_front()) begin
          report_failure("packet sent for an invalid address");
        end
        compare("out_packet_o", out_packet_o, exp_pkt_q.pop_front());
        sent_count++;
      end
      if (invalid_eva_access_o) begin
        if (exp_inv_q.size() == 0 || !exp_inv_q.pop_front()) begin
          report_failure("invalid_eva_access_o without an invalid request at the head");
        end
        void'(exp_pkt_q.pop_front());
      end
      if (fence_done_o) begin
        if (!in_fence) begin
          report_failure("fence_done_o pulsed with no fence pending");
        end
        compare("outstanding credits at fence_done_o", dut_out, 0);
        in_fence = 1'b0;
      end
      ret_pop = 1'b0;
      // head of the modeled return queue picks the stream
      ret_head_v = (ret_occ != 0);
      ret_head_type = remote_port_pkg::e_return_ifetch;
      if (ret_head_v) begin
        ret_head_type = exp_ret_q[0].pkt_type;
      end
      compare("ifetch_v_o", ifetch_v_o,
        ret_head_v && ret_head_type == remote_port_pkg::e_return_ifetch);
      compare("int_resp_v_o", int_resp_v_o,
        ret_head_v && ret_head_type == remote_port_pkg::e_return_int_wb);
      compare("float_resp_v_o", float_resp_v_o,
        ret_head_v && ret_head_type == remote_port_pkg::e_return_float_wb);
      compare("int_resp_force_o", int_resp_force_o, ret_head_v &&
        ret_head_type == remote_port_pkg::e_return_int_wb &&
        ret_occ == remote_port_pkg::ret_fifo_depth);
      compare("float_resp_force_o", float_resp_force_o, ret_head_v &&
        ret_head_type == remote_port_pkg::e_return_float_wb &&
        ret_occ == remote_port_pkg::ret_fifo_depth);
      if (ifetch_v_o) begin
        check_return(remote_port_pkg::e_return_ifetch, "ifetch", 5'd0, ifetch_instr_o);
      end
      if (int_resp_v_o && (int_resp_yumi_i || int_resp_force_o)) begin
        check_return(remote_port_pkg::e_return_int_wb, "int_resp", int_resp_rd_o,
          int_resp_data_o);
      end
      if (float_resp_v_o && (float_resp_yumi_i || float_resp_force_o)) begin
        check_return(remote_port_pkg::e_return_float_wb, "float_resp", float_resp_rd_o,
          float_resp_data_o);
      end
      ret_occ = ret_occ + returned_v_i - ret_pop;
    end
  end

  initial begin
    seed = 5646;
    clk_i = 1'b0;
    reset_i = 1'b1;
    remote_req_v_i = 1'b0;
    remote_req_addr_i = '0;
    remote_req_data_i = '0;
    remote_req_mask_i = '0;
    remote_req_amo_type_i = '0;
    remote_req_reg_id_i = '0;
    remote_req_write_not_read_i = 1'b0;
    remote_req_is_amo_i = 1'b0;
    remote_req_is_float_i = 1'b0;
    fence_i = 1'b0;
    out_credit_i = 1'b0;
    returned_v_i = 1'b0;
    returned_type_i = remote_port_pkg::e_return_ifetch;
    returned_reg_id_i = '0;
    returned_data_i = '0;
    tgo_x_i = $random(seed);
    tgo_y_i = $random(seed);
    my_x_i = $random(seed);
    my_y_i = $random(seed);
    dram_enable_i = 1'b1;
    int_resp_yumi_i = 1'b0;
    float_resp_yumi_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // quiet outputs before any stimulus
    repeat (4) begin
      @(negedge clk_i);
      compare("out_v_o", out_v_o, 0);
      compare("remote_req_credit_o", remote_req_credit_o, 0);
      compare("invalid_eva_access_o", invalid_eva_access_o, 0);
      compare("fence_done_o", fence_done_o, 0);
      compare("ifetch_v_o", ifetch_v_o, 0);
      compare("int_resp_v_o", int_resp_v_o, 0);
      compare("int_resp_force_o", int_resp_force_o, 0);
      compare("float_resp_v_o", float_resp_v_o, 0);
      compare("float_resp_force_o", float_resp_force_o, 0);
    end

    ret_todo = 120;
    repeat (60) begin
      issue_request($unsigned($random(seed)) % 4);
      if (($random(seed) & 3) == 0) begin
        next_cycle();
      end
    end
    wait_requests_done();

    // dram closed, so dram accesses get dropped too
    dram_enable_i = 1'b0;
    repeat (16) issue_request($unsigned($random(seed)) % 4);
    wait_requests_done();
    dram_enable_i = 1'b1;

    // network sits on its credits
    hold_credits = 1'b1;
    repeat (12) issue_request($unsigned($random(seed)) % 3);
    repeat (20) next_cycle();
    compare("packets in flight", sent_count - returned_count, remote_port_pkg::max_out_credits);
    compare("requests queued", exp_inv_q.size(), remote_port_pkg::req_fifo_depth);
    hold_credits = 1'b0;
    wait_requests_done();

    // fence with packets in flight
    repeat (6) issue_request($unsigned($random(seed)) % 3);
    next_cycle();
    fence_i = 1'b1;
    in_fence = 1'b1;
    wait_fence_done(200);
    wait_requests_done();

    // nothing outstanding, done on the next cycle
    fence_i = 1'b1;
    in_fence = 1'b1;
    wait_fence_done(2);

    wait_returns_done();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* remote_port.f */
verilog/remote_port_pkg.sv
verilog/eva_to_npa.sv
verilog/remote_fifo.sv
verilog/credit_counter.sv
verilog/fence_fsm.sv
verilog/network_tx.sv
verilog/remote_port.sv
verif/remote_port_tb.sv
